/* Makefile */
TOP := tb_f2_cpu_bus

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* list.f */
rtl/f2_bus_pkg.sv
rtl/cpu_bus_if.sv
rtl/address_decoder.sv
rtl/work_ram.sv
rtl/input_ports.sv
rtl/interrupt_ctrl.sv
rtl/bus_return.sv
rtl/f2_cpu_bus.sv
tests/tb_f2_cpu_bus.sv

/* rtl/address_decoder.sv */
`default_nettype none

module address_decoder (
    cpu_bus_if.decoder bus
);
    import f2_bus_pkg::*;

    logic [REGION_W-1:0] region;
    logic                iack;

    assign region = bus.addr[ADDR_W-1:RAM_AW];
    assign iack   = (bus.fc == FC_IACK);

    ////////////////////////////////////////////////////////////////////////////
    // Device select
    //
    // An acknowledge cycle wins over the address map, the CPU puts
    // the level on A3..A1 and the rest of the address is don't care

    always_comb begin
        bus.sel = DEV_NONE;

        if (!bus.as_n) begin
            if (iack) begin
                bus.sel = DEV_IACK;
            end else if (region == RAM_BASE) begin
                bus.sel = DEV_RAM;
            end else if (region == IO_BASE) begin
                bus.sel = DEV_IO;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_return.sv */
`default_nettype none

module bus_return (
    input  logic                  clk,
    input  logic                  reset,
    cpu_bus_if.ret                bus,
    input  f2_bus_pkg::cpu_word_t ram_rdata,
    input  f2_bus_pkg::cpu_word_t io_rdata,
    output f2_bus_pkg::cpu_word_t rdata,
    output logic                  dtack_n,
    output logic                  vpa_n
);
    import f2_bus_pkg::*;

    bus_state_t state;
    bus_state_t state_next;
    cpu_word_t  rd_mux;
    logic       cycle_req;

    assign cycle_req = ~bus.as_n & (bus.ds_n != 2'b11);

    always_comb begin
        case (bus.sel)
            DEV_RAM: rd_mux = ram_rdata;
            DEV_IO:  rd_mux = io_rdata;
            default: rd_mux = '0;    // Unmapped and IACK
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: if (cycle_req) state_next = BUS_WAIT;
            BUS_WAIT: state_next = bus.as_n ? BUS_IDLE : BUS_ACK;
            BUS_ACK:  if (bus.as_n) state_next = BUS_IDLE;
            default:  state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Device data settles one cycle after the select
    always_ff @(posedge clk) begin
        if (state == BUS_WAIT) begin
            rdata <= rd_mux;
        end
    end

    // Released as soon as the registered strobe goes high
    assign dtack_n = ~(state == BUS_ACK && !bus.as_n && bus.sel != DEV_IACK);
    assign vpa_n   = ~(state == BUS_ACK && !bus.as_n && bus.sel == DEV_IACK);

    assert property (@(posedge clk) disable iff (reset) !(!dtack_n && !vpa_n))
        else $error("dtack_n and vpa_n low together");

endmodule

`default_nettype wire

/* rtl/cpu_bus_if.sv */
`default_nettype none

interface cpu_bus_if;
    import f2_bus_pkg::*;

    // Registered copy of the CPU request
    logic      as_n;
    ds_n_t     ds_n;
    logic      rw;
    logic [2:0] fc;
    cpu_addr_t addr;
    cpu_word_t wdata;

    dev_sel_t  sel;   // From the decoder

    modport decoder (input as_n, fc, addr, output sel);

    modport device (input as_n, ds_n, rw, fc, addr, wdata, sel);

    modport ret (input as_n, ds_n, sel);

endinterface

`default_nettype wire

/* rtl/f2_bus_pkg.sv */
`default_nettype none

package f2_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Address map and widths

    localparam int ADDR_W   = 23;              // Word address, A23..A1
    localparam int DATA_W   = 16;
    localparam int RAM_AW   = 15;              // 32K words of work RAM
    localparam int IO_AW    = 3;
    localparam int REGION_W = ADDR_W - RAM_AW; // Bits above a 64 KiB block

    localparam logic [REGION_W-1:0] RAM_BASE = 8'h10; // 0x10xxxx
    localparam logic [REGION_W-1:0] IO_BASE  = 8'h30; // 0x30xxxx

    ////////////////////////////////////////////////////////////////////////////
    // Interrupts

    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;
    localparam logic [2:0] FC_IACK       = 3'd7; // CPU space

    ////////////////////////////////////////////////////////////////////////////
    // Bus types

    typedef logic [ADDR_W-1:0] cpu_addr_t;
    typedef logic [DATA_W-1:0] cpu_word_t;
    typedef logic [1:0]        ds_n_t;     // [1] upper, [0] lower
    typedef logic [2:0]        ipl_t;      // Active low
    typedef logic [9:0]        joy_t;      // [3:0] U D L R, [6:4] buttons 1-3

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_RAM,
        DEV_IO,
        DEV_IACK
    } dev_sel_t;

    typedef enum logic [2:0] {
        IO_DSWA,
        IO_DSWB,
        IO_P1,
        IO_P2,
        IO_SYS
    } io_reg_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT,
        BUS_ACK
    } bus_state_t;

endpackage

`default_nettype wire

/* rtl/f2_cpu_bus.sv */
`default_nettype none

module f2_cpu_bus (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  as_n,
    input  f2_bus_pkg::ds_n_t     ds_n,
    input  logic                  rw,
    input  logic [2:0]            fc,
    input  f2_bus_pkg::cpu_addr_t addr,
    input  f2_bus_pkg::cpu_word_t wdata,

    input  logic                  vblank_n,
    input  logic                  dma_n,

    input  logic [7:0]            dswa,
    input  logic [7:0]            dswb,
    input  f2_bus_pkg::joy_t      joy_p1,
    input  f2_bus_pkg::joy_t      joy_p2,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,

    output f2_bus_pkg::cpu_word_t rdata,
    output logic                  dtack_n,
    output logic                  vpa_n,
    output f2_bus_pkg::ipl_t      ipl_n
);
    import f2_bus_pkg::*;

    cpu_word_t ram_rdata;
    cpu_word_t io_rdata;

    cpu_bus_if bus();

    ////////////////////////////////////////////////////////////////////////////
    // Request register, devices only see the registered copy

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.as_n <= 1'b1;
            bus.ds_n <= 2'b11;
        end else begin
            bus.as_n <= as_n;
            bus.ds_n <= ds_n;
        end
    end

    always_ff @(posedge clk) begin
        bus.rw    <= rw;
        bus.fc    <= fc;
        bus.addr  <= addr;
        bus.wdata <= wdata;
    end

    address_decoder address_decoder (.bus(bus.decoder));

    work_ram work_ram (.clk, .bus(bus.device), .rdata(ram_rdata));

    input_ports input_ports (
        .clk, .reset, .bus(bus.device),
        .dswa, .dswb, .joy_p1, .joy_p2, .start, .coin,
        .rdata(io_rdata)
    );

    interrupt_ctrl interrupt_ctrl (.clk, .reset, .bus(bus.device), .vblank_n, .dma_n, .ipl_n);

    bus_return bus_return (
        .clk, .reset, .bus(bus.ret),
        .ram_rdata, .io_rdata,
        .rdata, .dtack_n, .vpa_n
    );

endmodule

`default_nettype wire

/* rtl/input_ports.sv */
`default_nettype none

module input_ports (
    input  logic                  clk,
    input  logic                  reset,
    cpu_bus_if.device             bus,
    input  logic [7:0]            dswa,
    input  logic [7:0]            dswb,
    input  f2_bus_pkg::joy_t      joy_p1,
    input  f2_bus_pkg::joy_t      joy_p2,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,
    output f2_bus_pkg::cpu_word_t rdata
);
    import f2_bus_pkg::*;

    io_reg_t    idx;
    logic [7:0] port_byte;

    assign idx = io_reg_t'(bus.addr[IO_AW-1:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Register select, active high here

    always_comb begin
        case (idx)
            IO_DSWA: port_byte = dswa;
            IO_DSWB: port_byte = dswb;
            IO_P1:   port_byte = {start[0], joy_p1[6:0]}; // Start, B3..B1, R L D U
            IO_P2:   port_byte = {start[1], joy_p2[6:0]};
            IO_SYS:  port_byte = {2'b00, start, coin, 2'b00};
            default: port_byte = 8'h00;
        endcase
    end

    // Inputs are active low on the bus, same byte on both lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '1;
        end else if (bus.sel == DEV_IO) begin
            rdata <= {~port_byte, ~port_byte};
        end
    end

endmodule

`default_nettype wire

/* rtl/interrupt_ctrl.sv */
`default_nettype none

module interrupt_ctrl (
    input  logic             clk,
    input  logic             reset,
    cpu_bus_if.device        bus,
    input  logic             vblank_n,
    input  logic             dma_n,
    output f2_bus_pkg::ipl_t ipl_n
);
    import f2_bus_pkg::*;

    logic vbl_q;
    logic vbl_prev;
    logic dma_q;
    logic dma_prev;
    logic req_vbl;
    logic req_dma;
    logic clr_vbl;
    logic clr_dma;

    // Acknowledge cycle for a given level, level is on A3..A1
    assign clr_vbl = (bus.sel == DEV_IACK) && (bus.addr[2:0] == IRQ_VBL_LEVEL) && !bus.ds_n[0];
    assign clr_dma = (bus.sel == DEV_IACK) && (bus.addr[2:0] == IRQ_DMA_LEVEL) && !bus.ds_n[0];

    ////////////////////////////////////////////////////////////////////////////
    // Input registers and requests

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_q    <= 1'b1;
            vbl_prev <= 1'b1;
            dma_q    <= 1'b1;
            dma_prev <= 1'b1;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_q    <= vblank_n;
            vbl_prev <= vbl_q;
            dma_q    <= dma_n;
            dma_prev <= dma_q;

            if (vbl_prev && !vbl_q) begin  // Start of vblank
                req_vbl <= 1'b1;
            end
            if (!dma_prev && dma_q) begin  // Sprite DMA finished
                req_dma <= 1'b1;
            end

            if (clr_vbl) begin
                req_vbl <= 1'b0;
            end
            if (clr_dma) begin
                req_dma <= 1'b0;
            end
        end
    end

    always_comb begin
        if (req_dma) begin
            ipl_n = ~IRQ_DMA_LEVEL;
        end else if (req_vbl) begin
            ipl_n = ~IRQ_VBL_LEVEL;
        end else begin
            ipl_n = 3'b111;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (ipl_n == 3'b111) || (ipl_n == ~IRQ_VBL_LEVEL) || (ipl_n == ~IRQ_DMA_LEVEL))
        else $error("ipl_n shows an unused level");

endmodule

`default_nettype wire

/* rtl/work_ram.sv */
`default_nettype none

module work_ram #(
    parameter int RAM_AW = f2_bus_pkg::RAM_AW
) (
    input  logic                  clk,
    cpu_bus_if.device             bus,
    output f2_bus_pkg::cpu_word_t rdata
);
    import f2_bus_pkg::*;

    cpu_word_t         mem [2**RAM_AW];
    logic [RAM_AW-1:0] word_addr;
    logic              cs;
    logic              we_hi;
    logic              we_lo;

    assign word_addr = bus.addr[RAM_AW-1:0];
    assign cs        = (bus.sel == DEV_RAM);

    // Separate lane enables from UDS and LDS
    assign we_hi = cs & ~bus.rw & ~bus.ds_n[1];
    assign we_lo = cs & ~bus.rw & ~bus.ds_n[0];

    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[word_addr][15:8] <= bus.wdata[15:8];
        end
        if (we_lo) begin
            mem[word_addr][7:0] <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cs) begin
            rdata <= mem[word_addr]; // Old word on a write cycle
        end
    end

    // Select comes from the decoder, so this ties it to the strobe
    assert property (@(posedge clk) (we_hi || we_lo) |-> !bus.as_n)
        else $error("work RAM written with as_n high");

endmodule

`default_nettype wire

/* tests/bus_cases.txt */
# op addr(word) ds_n data expect, all hex; ds_n 0 both, 1 upper only, 2 lower only
# W write, R read, A int ack (addr = level), I set input (addr 0..5 = dswa dswb p1 p2 start coin)
# V vblank pulse, D DMA done pulse, L check ipl_n (expect is active low)
L 000000 3 0000 7
W 080000 0 1234 0000
W 087fff 0 beef 0000
W 080100 0 5a5a 0000
W 080010 0 0f0f 0000
W 084321 0 c001 0000
R 080000 0 0000 1234
R 087fff 0 0000 beef
R 080100 0 0000 5a5a
R 084321 0 0000 c001
W 080100 1 ab00 0000
R 080100 0 0000 ab5a
W 080100 2 00cd 0000
R 080100 0 0000 abcd
I 000000 3 00a5 0000
I 000001 3 003c 0000
I 000002 3 03da 0000
I 000003 3 0021 0000
I 000004 3 0001 0000
I 000005 3 0002 0000
R 180000 0 0000 5a5a
R 180001 0 0000 c3c3
R 180002 0 0000 2525
R 180003 0 0000 dede
R 180004 0 0000 e7e7
R 180005 0 0000 ffff
W 180000 0 0000 0000
R 180000 0 0000 5a5a
R 200000 0 0000 0000
W 200010 0 dead 0000
R 080010 0 0000 0f0f
R 087fff 0 0000 beef
V 000000 3 0000 0000
L 000000 3 0000 2
D 000000 3 0000 0000
L 000000 3 0000 1
A 000006 0 0000 0000
L 000000 3 0000 2
A 000005 0 0000 0000
L 000000 3 0000 7

/* tests/tb_f2_cpu_bus.sv */
`default_nettype none

module tb_f2_cpu_bus;
    timeunit 1ns;
    timeprecision 1ps;

    import f2_bus_pkg::*;

    localparam int         RESET_CYCLES    = 10;
    localparam int         CYCLES_PER_CASE = 40;
    localparam int         ACK_LIMIT       = 8;
    localparam int         PULSE_CYCLES    = 4;
    localparam int         SETTLE_CYCLES   = 4;
    localparam logic [2:0] FC_DATA         = 3'd5;  // Supervisor data

    logic       clk;
    logic       reset;
    logic       as_n;
    ds_n_t      ds_n;
    logic       rw;
    logic [2:0] fc;
    cpu_addr_t  addr;
    cpu_word_t  wdata;
    logic       vblank_n;
    logic       dma_n;
    logic [7:0] dswa;
    logic [7:0] dswb;
    joy_t       joy_p1;
    joy_t       joy_p2;
    logic [1:0] start;
    logic [1:0] coin;
    cpu_word_t  rdata;
    logic       dtack_n;
    logic       vpa_n;
    ipl_t       ipl_n;

    // One entry per line of the case file
    logic [7:0]  case_op[$];
    logic [31:0] case_addr[$];
    logic [31:0] case_ds[$];
    logic [31:0] case_data[$];
    logic [31:0] case_exp[$];

    int cycles;
    int cycle_limit;

    f2_cpu_bus dut (
        .clk, .reset,
        .as_n, .ds_n, .rw, .fc, .addr, .wdata,
        .vblank_n, .dma_n,
        .dswa, .dswb, .joy_p1, .joy_p2, .start, .coin,
        .rdata, .dtack_n, .vpa_n, .ipl_n
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles, the run did not finish",
                                        cycles));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cpu_word_t expected,
                              input cpu_word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR: %s expected %h, got %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_ipl(input string name, input ipl_t expected, input ipl_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR: %s expected %h, got %h",
                                        name, expected, actual));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("tests/bus_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open tests/bus_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h", op, a, s, d, e);
            if (n != 5) begin
                stop_with_failure({"Malformed line in the case file: ", line});
            end
            case_op.push_back(op);
            case_addr.push_back(a);
            case_ds.push_back(s);
            case_data.push_back(d);
            case_exp.push_back(e);
        end
        $fclose(fd);
        if (case_op.size() == 0) begin
            stop_with_failure("The case file holds no cases");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus master

    task automatic bus_access(input logic iack, input logic rw_v, input logic [2:0] fc_v,
                              input cpu_addr_t a, input ds_n_t ds, input cpu_word_t wd,
                              output cpu_word_t rd);
        int waited;
        @(negedge clk);
        if (!dtack_n || !vpa_n) begin
            stop_with_failure("Acknowledge was low before the address strobe fell");
        end
        addr  = a;
        rw    = rw_v;
        fc    = fc_v;
        ds_n  = ds;
        wdata = wd;
        @(negedge clk);
        if (!dtack_n || !vpa_n) begin
            stop_with_failure("Acknowledge was low before the address strobe fell");
        end
        as_n   = 1'b0;
        waited = 0;
        while (dtack_n && vpa_n) begin
            if (waited == ACK_LIMIT) begin
                stop_with_failure($sformatf("No acknowledge for address %h", a));
            end
            @(negedge clk);
            waited++;
        end
        if (!dtack_n && !vpa_n) begin
            stop_with_failure("dtack_n and vpa_n were low in the same cycle");
        end
        if (iack && !dtack_n) begin
            stop_with_failure("Interrupt acknowledge was answered by dtack_n, not vpa_n");
        end
        if (!iack && !vpa_n) begin
            stop_with_failure("Memory cycle was answered by vpa_n, not dtack_n");
        end
        rd     = rdata;
        as_n   = 1'b1;
        ds_n   = 2'b11;
        waited = 0;
        while (!dtack_n || !vpa_n) begin  // Release after as_n rises
            if (waited == 2) begin
                stop_with_failure("Acknowledge still low two cycles after as_n rose");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic set_input(input int which, input logic [15:0] value);
        @(negedge clk);
        case (which)
            0: dswa   = value[7:0];
            1: dswb   = value[7:0];
            2: joy_p1 = value[9:0];
            3: joy_p2 = value[9:0];
            4: start  = value[1:0];
            5: coin   = value[1:0];
            default: stop_with_failure($sformatf("Unknown input index %0d", which));
        endcase
    endtask

    task automatic pulse_vblank();
        @(negedge clk);
        vblank_n = 1'b0;
        repeat (PULSE_CYCLES) @(negedge clk);
        vblank_n = 1'b1;
    endtask

    task automatic pulse_dma_done();
        @(negedge clk);
        dma_n = 1'b0;
        repeat (PULSE_CYCLES) @(negedge clk);
        dma_n = 1'b1;  // Rising edge ends the DMA
    endtask

    task automatic run_case(input int i);
        cpu_word_t rd;
        case (case_op[i])
            "W": bus_access(1'b0, 1'b0, FC_DATA, case_addr[i][ADDR_W-1:0],
                            case_ds[i][1:0], case_data[i][15:0], rd);
            "R": begin
                bus_access(1'b0, 1'b1, FC_DATA, case_addr[i][ADDR_W-1:0],
                           case_ds[i][1:0], '0, rd);
                check_word("rdata", case_exp[i][15:0], rd);
            end
            "A": begin
                bus_access(1'b1, 1'b1, FC_IACK, case_addr[i][ADDR_W-1:0],
                           case_ds[i][1:0], '0, rd);
                check_word("rdata", case_exp[i][15:0], rd);
            end
            "I": set_input(case_addr[i], case_data[i][15:0]);
            "V": pulse_vblank();
            "D": pulse_dma_done();
            "L": begin
                repeat (SETTLE_CYCLES) @(negedge clk);
                check_ipl("ipl_n", case_exp[i][2:0], ipl_n);
            end
            default: stop_with_failure($sformatf("Unknown operation on case %0d", i));
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        as_n        = 1'b1;
        ds_n        = 2'b11;
        rw          = 1'b1;
        fc          = 3'd0;
        addr        = '0;
        wdata       = '0;
        vblank_n    = 1'b1;
        dma_n       = 1'b1;
        dswa        = 8'h00;
        dswb        = 8'h00;
        joy_p1      = '0;
        joy_p2      = '0;
        start       = 2'b00;
        coin        = 2'b00;
        cycles      = 0;
        cycle_limit = 0;

        load_cases();
        cycle_limit = 2 * RESET_CYCLES + CYCLES_PER_CASE * case_op.size();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < case_op.size(); i++) begin
            run_case(i);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
